/* common/toy_cpu_pkg.sv */
// shared word, byte and index types plus the opcode constants of the toy cpu
package toy_cpu_pkg;

    // instruction and memory data word
    typedef logic [15:0] word_t;

    // register contents and immediates
    typedef logic [7:0] byte_t;

    // register index field, bits 15..12 of an instruction
    typedef logic [3:0] reg_idx_t;

    // opcode field, bits 11..8 of an instruction
    typedef logic [3:0] opcode_t;

    // stops the core, as does any opcode not listed here
    localparam opcode_t OP_HALT = 4'd0;

    // emit the immediate, zero-extended
    localparam opcode_t OP_OUT_IMM = 4'd1;

    // emit memory word at immediate/2
    localparam opcode_t OP_OUT_LOC = 4'd2;

    // write the immediate into a register
    localparam opcode_t OP_LOAD_IMM = 4'd3;

    // emit a register, zero-extended
    localparam opcode_t OP_OUT_REG = 4'd4;

endpackage

/* cpu_core/reg_file.sv */
// register file: sixteen 8-bit registers, one write port, one combinational read port
module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  toy_cpu_pkg::reg_idx_t waddr,
    input  toy_cpu_pkg::byte_t    wdata,
    input  toy_cpu_pkg::reg_idx_t raddr,
    output toy_cpu_pkg::byte_t    rdata
);
    import toy_cpu_pkg::*;

    localparam int NUM_REGS = 16;

    byte_t regs [NUM_REGS];

    // all registers read as zero after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // no read-during-write bypass; OUT_REG and LOAD_IMM never share a cycle
    assign rdata = regs[raddr];

endmodule

/* cpu_core/cpu_core.sv */
// cpu core: fetch/execute state machine, Wishbone classic read master, register file
module cpu_core #(
    parameter int MEM_AWIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  toy_cpu_pkg::word_t     wb_dat_r,
    input  logic                   wb_ack,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic [MEM_AWIDTH-1:0]  wb_adr,
    output logic                   out_valid,
    output toy_cpu_pkg::word_t     out_data,
    output logic                   halted
);
    import toy_cpu_pkg::*;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT,
        DATA_WAIT,
        HALT
    } state_t;

    state_t                state;
    logic [MEM_AWIDTH-1:0] pc;
    logic                  bus_req;
    opcode_t               op_q;

    // fields of the word on the read bus
    reg_idx_t fetch_idx;
    opcode_t  fetch_op;
    byte_t    fetch_imm;
    logic     fetch_done;

    logic     rf_we;
    reg_idx_t rf_waddr;
    byte_t    rf_wdata;
    reg_idx_t rf_raddr;
    byte_t    rf_rdata;

    assign fetch_idx  = wb_dat_r[15:12];
    assign fetch_op   = wb_dat_r[11:8];
    assign fetch_imm  = wb_dat_r[7:0];
    assign fetch_done = (state == FETCH_WAIT) && wb_ack;

    // LOAD_IMM writes straight from the acked word
    assign rf_we    = fetch_done && (fetch_op == OP_LOAD_IMM);
    assign rf_waddr = fetch_idx;
    assign rf_wdata = fetch_imm;
    assign rf_raddr = fetch_idx;

    reg_file u_reg_file (
        .clk   (clk),
        .rst   (rst),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

    // cyc and stb always move together, one transfer at a time
    assign wb_cyc = bus_req;
    assign wb_stb = bus_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= FETCH_REQ;
            pc        <= '0;
            bus_req   <= 1'b0;
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                FETCH_REQ: begin
                    wb_adr  <= pc;
                    bus_req <= 1'b1;
                    state   <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (wb_ack) begin
                        op_q <= fetch_op;
                        case (fetch_op)
                            OP_OUT_IMM: begin
                                out_valid <= 1'b1;
                                out_data  <= {8'h00, fetch_imm};
                                pc        <= pc + 1'b1;
                                wb_adr    <= pc + 1'b1;
                            end
                            OP_LOAD_IMM: begin
                                // register write happens through rf_we
                                pc     <= pc + 1'b1;
                                wb_adr <= pc + 1'b1;
                            end
                            OP_OUT_REG: begin
                                out_valid <= 1'b1;
                                out_data  <= {8'h00, rf_rdata};
                                pc        <= pc + 1'b1;
                                wb_adr    <= pc + 1'b1;
                            end
                            OP_OUT_LOC: begin
                                // stb stays up, the address moves to the operand
                                wb_adr <= MEM_AWIDTH'(fetch_imm >> 1);
                                state  <= DATA_WAIT;
                            end
                            default: begin
                                bus_req <= 1'b0;
                                halted  <= 1'b1;
                                state   <= HALT;
                            end
                        endcase
                    end
                end
                DATA_WAIT: begin
                    if (wb_ack) begin
                        bus_req <= 1'b0;
                        case (op_q)
                            OP_OUT_LOC: begin
                                out_valid <= 1'b1;
                                out_data  <= wb_dat_r;
                                pc        <= pc + 1'b1;
                                state     <= FETCH_REQ;
                            end
                            default: begin
                                halted <= 1'b1;
                                state  <= HALT;
                            end
                        endcase
                    end
                end
                default: begin
                    // halted, no further bus cycles
                    bus_req <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* hdl/program_mem.sv */
// program memory: word array with Wishbone classic read slave and reset-time load port
module program_mem #(
    parameter int MEM_AWIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_en,
    input  logic [MEM_AWIDTH-1:0] load_addr,
    input  toy_cpu_pkg::word_t    load_data,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic [MEM_AWIDTH-1:0] wb_adr,
    output toy_cpu_pkg::word_t    wb_dat_r,
    output logic                  wb_ack
);
    import toy_cpu_pkg::*;

    localparam int DEPTH = 2 ** MEM_AWIDTH;

    word_t mem [DEPTH];
    logic  bus_sel;

    assign bus_sel = wb_cyc && wb_stb;

    // program load, only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // one wait state, ack pulses for a single cycle per request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_sel && !wb_ack;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (bus_sel) begin
            wb_dat_r <= mem[wb_adr];
        end
    end

endmodule

/* hdl/toy_cpu_top.sv */
// top level: cpu core and program memory joined by the Wishbone classic read bus
module toy_cpu_top #(
    parameter int MEM_AWIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_en,
    input  logic [MEM_AWIDTH-1:0] load_addr,
    input  toy_cpu_pkg::word_t    load_data,
    output logic                  out_valid,
    output toy_cpu_pkg::word_t    out_data,
    output logic                  halted
);
    import toy_cpu_pkg::*;

    // wishbone wires
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [MEM_AWIDTH-1:0] wb_adr;
    word_t                 wb_dat_r;
    logic                  wb_ack;

    cpu_core #(
        .MEM_AWIDTH (MEM_AWIDTH)
    ) u_cpu_core (
        .clk       (clk),
        .rst       (rst),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    program_mem #(
        .MEM_AWIDTH (MEM_AWIDTH)
    ) u_program_mem (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

endmodule

/* testbench/tb_toy_cpu.sv */
// testbench for toy_cpu_top: program loader, reference model, output compare and watchdog
module tb_toy_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_AWIDTH = 8;
    localparam int DEPTH = 2 ** MEM_AWIDTH;
    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int QUIET_CYCLES = 20;

    localparam int OP_HALT = 0;
    localparam int OP_OUT_IMM = 1;
    localparam int OP_OUT_LOC = 2;
    localparam int OP_LOAD_IMM = 3;
    localparam int OP_OUT_REG = 4;

    logic                  clk;
    logic                  rst;
    logic                  load_en;
    logic [MEM_AWIDTH-1:0] load_addr;
    logic [15:0]           load_data;
    logic                  out_valid;
    logic [15:0]           out_data;
    logic                  halted;

    // memory image as loaded, and the outputs the model expects from it
    logic [15:0] image [DEPTH];
    logic [15:0] expected_q [$];

    int    prog_len;
    int    seed;
    int    errors;
    int    out_errors = 0;
    int    seen_count;
    int    run_cycles;
    int    run_limit;
    logic  running;
    string test_name;

    toy_cpu_top #(
        .MEM_AWIDTH (MEM_AWIDTH)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic logic [15:0] encode(input int idx, input int op, input int imm);
        return {4'(idx), 4'(op), 8'(imm)};
    endfunction

    // odd multiplier keeps every fill word distinct across the address space
    function automatic void clear_image();
        for (int a = 0; a < DEPTH; a++) begin
            image[a] = 16'(a * 40503) ^ 16'h5a5a;
        end
        prog_len = 0;
    endfunction

    function automatic void append_instr(input int idx, input int op, input int imm);
        image[prog_len] = encode(idx, op, imm);
        prog_len = prog_len + 1;
    endfunction

    // walks the image from pc 0, fills expected_q, returns the pc of the halting word
    function automatic int run_model();
        logic [7:0]  regs [16];
        logic [15:0] word;
        logic [3:0]  idx;
        logic [3:0]  op;
        logic [7:0]  imm;
        int          pc;
        int          steps;
        bit          done;
        for (int i = 0; i < 16; i++) begin
            regs[i] = 8'h00;
        end
        expected_q.delete();
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < DEPTH) begin
            word = image[pc];
            idx = word[15:12];
            op = word[11:8];
            imm = word[7:0];
            case (int'(op))
                OP_OUT_IMM: expected_q.push_back({8'h00, imm});
                OP_OUT_LOC: expected_q.push_back(image[int'(imm >> 1)]);
                OP_LOAD_IMM: regs[idx] = imm;
                OP_OUT_REG: expected_q.push_back({8'h00, regs[idx]});
                default: done = 1'b1;
            endcase
            if (!done) begin
                pc = (pc + 1) % DEPTH;
            end
            steps++;
        end
        return pc;
    endfunction

    task automatic build_random_program(input int length);
        int op;
        clear_image();
        for (int i = 0; i < length - 1; i++) begin
            op = 1 + int'($unsigned($random(seed)) % 4);
            append_instr($unsigned($random(seed)) % 16, op, $unsigned($random(seed)) % 256);
        end
        // last word halts, either opcode 0 or one of the unlisted ones
        op = int'($unsigned($random(seed)) % 12);
        if (op != 0) begin
            op = op + 4;
        end
        append_instr($unsigned($random(seed)) % 16, op, $unsigned($random(seed)) % 256);
    endtask

    // loads the image under reset, releases the core and waits for halt
    task automatic run_program(input string name);
        int halt_pos;
        test_name = name;
        @(posedge clk);
        rst <= 1'b1;
        for (int a = 0; a < DEPTH; a++) begin
            load_en   <= 1'b1;
            load_addr <= MEM_AWIDTH'(a);
            load_data <= image[a];
            @(posedge clk);
        end
        load_en <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        halt_pos = run_model();
        run_limit = (halt_pos + 1) * 6 + 100;
        running = 1'b1;
        rst <= 1'b0;
        // fetch request, ack, then the first result: nothing shows before that
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || halted !== 1'b0) begin
                errors++;
                $display("test %s: out_valid or halted high before the first result", name);
            end
        end
        while (halted !== 1'b1) @(negedge clk);
        repeat (QUIET_CYCLES) @(negedge clk);
        if (halted !== 1'b1) begin
            errors++;
            $display("test %s: halted dropped after the core stopped", name);
        end
        @(posedge clk);
        if (seen_count != expected_q.size()) begin
            errors++;
            $display("[ERROR] %s output count: expected %0d, actual %0d",
                     name, expected_q.size(), seen_count);
        end
        running = 1'b0;
    endtask

    always @(negedge clk) begin : compare_outputs
        if (rst) begin
            seen_count = 0;
        end else if (out_valid) begin
            if (seen_count >= expected_q.size()) begin
                out_errors++;
                $display("test %s: output %h came after all expected outputs", test_name,
                         out_data);
            end else if (out_data !== expected_q[seen_count]) begin
                out_errors++;
                $display("[ERROR] %s: expected %h, actual %h", test_name,
                         expected_q[seen_count], out_data);
            end
            seen_count++;
        end
    end

    always @(posedge clk) begin : watchdog
        if (!running) begin
            run_cycles = 0;
        end else begin
            run_cycles = run_cycles + 1;
            if (run_cycles > run_limit) begin
                $display("timeout: test %s did not halt within %0d cycles", test_name,
                         run_limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    initial begin
        int len;
        clk = 1'b0;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed = 32'h4a48_5b69;
        errors = 0;
        running = 1'b0;
        run_limit = 0;

        clear_image();
        append_instr(1, OP_LOAD_IMM, 8'h11);
        append_instr(5, OP_LOAD_IMM, 8'ha7);
        append_instr(15, OP_LOAD_IMM, 8'hff);
        append_instr(1, OP_OUT_REG, 0);
        append_instr(5, OP_OUT_REG, 0);
        append_instr(15, OP_OUT_REG, 0);
        append_instr(2, OP_OUT_REG, 0);
        append_instr(0, OP_OUT_IMM, 8'h3c);
        append_instr(9, OP_OUT_IMM, 8'h80);
        append_instr(5, OP_LOAD_IMM, 8'h42);
        append_instr(5, OP_OUT_REG, 0);
        append_instr(0, OP_HALT, 0);
        run_program("directed");

        // even and odd immediates land on the same word
        clear_image();
        image[8'h40] = 16'hbeef;
        image[8'h41] = 16'h8001;
        image[8'h7f] = 16'h7ffe;
        append_instr(0, OP_OUT_LOC, 8'h80);
        append_instr(3, OP_OUT_LOC, 8'h81);
        append_instr(0, OP_OUT_LOC, 8'h82);
        append_instr(0, OP_OUT_LOC, 8'h83);
        append_instr(0, OP_OUT_LOC, 8'hfe);
        append_instr(0, OP_OUT_LOC, 8'hff);
        append_instr(0, OP_OUT_LOC, 8'h01);
        append_instr(0, OP_HALT, 0);
        run_program("out_loc");

        clear_image();
        append_instr(0, OP_OUT_REG, 0);
        append_instr(1, OP_OUT_REG, 0);
        append_instr(5, OP_OUT_REG, 0);
        append_instr(15, OP_OUT_REG, 0);
        append_instr(0, OP_HALT, 0);
        run_program("reset_state");

        clear_image();
        append_instr(0, OP_OUT_IMM, 8'h12);
        append_instr(7, OP_HALT, 8'h99);
        append_instr(0, OP_OUT_IMM, 8'h34);
        append_instr(1, OP_OUT_REG, 0);
        run_program("halt");

        clear_image();
        append_instr(2, OP_LOAD_IMM, 8'h5a);
        append_instr(2, OP_OUT_REG, 0);
        append_instr(4, 11, 8'h21);
        append_instr(0, OP_OUT_IMM, 8'h78);
        run_program("unknown_op");

        for (int i = 1; i <= 3; i++) begin
            len = 16 + int'($unsigned($random(seed)) % 24);
            build_random_program(len);
            run_program($sformatf("random_%0d", i));
        end

        $display("errors: %0d output mismatches, %0d other failures", out_errors, errors);
        if (errors == 0 && out_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/toy_cpu_pkg.sv
cpu_core/reg_file.sv
cpu_core/cpu_core.sv
hdl/program_mem.sv
hdl/toy_cpu_top.sv
testbench/tb_toy_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_toy_cpu -f vlog.f -o tb_toy_cpu \
    && ./obj_dir/tb_toy_cpu | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
